/* src/axi_burst_pkg.sv */
// AXI4 widths, response codes and channel payload structs
// Shared by every DMA engine and by the slave model
`default_nettype none

package axi_burst_pkg;

   localparam int beat_bytes = 8;     // Byte step between beats, 64-bit bus

   ////////////////////////////////////////////////////////////
   // Field widths
   ////////////////////////////////////////////////////////////
   typedef logic [31:0] axi_addr_t;   // Byte address
   typedef logic [7:0]  axi_len_t;    // Burst length, beats minus one
   typedef logic [63:0] axi_data_t;   // One data beat

   // Response codes for B and R
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_exokay = 2'b01,
      resp_slverr = 2'b10,
      resp_decerr = 2'b11
   } axi_resp_e;

   ////////////////////////////////////////////////////////////
   // Channel payloads
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      axi_addr_t addr;                // First beat address
      axi_len_t  len;                 // AxLEN
   } axi_ax_t;                        // AW and AR, 40 bits

   typedef struct packed {
      axi_data_t data;
      logic      last;                // WLAST
   } axi_w_t;                         // 65 bits

   typedef struct packed {
      axi_data_t data;
      axi_resp_e resp;                // Per-beat RRESP
      logic      last;                // RLAST
   } axi_r_t;                         // 67 bits

endpackage

`default_nettype wire

/* src/dma_ctrl_pkg.sv */
// DMA command struct and the state encodings of the four channel engines
`default_nettype none

package dma_ctrl_pkg;

   import axi_burst_pkg::*;

   // One burst request from the local side
   typedef struct packed {
      axi_addr_t addr;                // Start byte address, beat aligned
      axi_len_t  count;               // Beats minus one
   } dma_cmd_t;                       // 40 bits

   ////////////////////////////////////////////////////////////
   // Engine states
   ////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      aw_idle,                        // Command ready high
      aw_wait_ready,                  // AW presented
      aw_wait_resp,                   // Waiting on B
      aw_error                        // Sticky until reset
   } wr_addr_state_e;

   typedef enum logic [1:0] {
      dw_idle,
      dw_run,                         // Beats before the last one
      dw_last                         // WLAST beat pending
   } wr_data_state_e;

   typedef enum logic [1:0] {
      ar_idle,
      ar_wait_ready,
      ar_wait_done,                   // Waiting on the read data verdict
      ar_error
   } rd_addr_state_e;

   typedef enum logic [1:0] {
      dr_idle,
      dr_run,                         // Counting and checking beats
      dr_drain,                       // Error seen, flushing to RLAST
      dr_error
   } rd_data_state_e;

endpackage

`default_nettype wire

/* src/dma_write_addr.sv */
// Write path address engine
// Takes a command, drives AW, then waits for and checks the B response
`timescale 1ns/1ps
`default_nettype none

module dma_write_addr
   import axi_burst_pkg::*, dma_ctrl_pkg::*;
(
   input  wire logic      aclk,
   input  wire logic      areset,
   // Command side
   input  wire dma_cmd_t  wr_cmd,
   input  wire logic      wr_cmd_valid,
   output logic           wr_cmd_ready,
   // AXI write address
   output axi_ax_t        m_axi_aw,
   output logic           m_axi_awvalid,
   input  wire logic      m_axi_awready,
   // AXI write response
   input  wire axi_resp_e m_axi_bresp,
   input  wire logic      m_axi_bvalid,
   output logic           m_axi_bready,
   // Start strobe to the data engine
   output logic           wr_start,
   output axi_len_t       wr_start_len,
   // Status
   output logic           wr_error,
   output axi_resp_e      wr_error_resp
);

   wr_addr_state_e state;
   logic           cmd_accept;        // Command handshake this cycle
   logic           resp_good;         // OKAY or EXOKAY on B

   assign cmd_accept = wr_cmd_valid && wr_cmd_ready;
   assign resp_good  = (m_axi_bresp == resp_okay) || (m_axi_bresp == resp_exokay);

   // Handshake outputs straight from the state register
   assign wr_cmd_ready  = (state == aw_idle);
   assign m_axi_awvalid = (state == aw_wait_ready);   // Held until awready
   assign m_axi_bready  = (state == aw_wait_resp);
   assign wr_error      = (state == aw_error);

   assign wr_start     = cmd_accept;                  // One cycle, at acceptance
   assign wr_start_len = wr_cmd.count;

   ////////////////////////////////////////////////////////////
   // State machine
   ////////////////////////////////////////////////////////////
   always_ff @(posedge aclk) begin
      if (areset) begin
         state         <= aw_idle;
         wr_error_resp <= resp_okay;
      end else begin
         case (state)
            aw_idle: begin
               if (cmd_accept) begin
                  state <= aw_wait_ready;
               end
            end
            aw_wait_ready: begin
               if (m_axi_awready) begin
                  state <= aw_wait_resp;              // Address taken, wait on B
               end
            end
            aw_wait_resp: begin
               if (m_axi_bvalid) begin
                  if (resp_good) begin
                     state <= aw_idle;
                  end else begin
                     state         <= aw_error;       // SLVERR or DECERR
                     wr_error_resp <= m_axi_bresp;    // Keep it for status
                  end
               end
            end
            default: state <= aw_error;               // aw_error holds until reset
         endcase
      end
   end

   // AW payload, loaded on acceptance and stable while awvalid is up
   always_ff @(posedge aclk) begin
      if (cmd_accept) begin
         m_axi_aw.addr <= wr_cmd.addr;
         m_axi_aw.len  <= wr_cmd.count;
      end
   end

endmodule

`default_nettype wire

/* src/dma_write_data.sv */
// Write path data engine
// Beat counter gating the local stream onto W, with WLAST on the final beat
`timescale 1ns/1ps
`default_nettype none

module dma_write_data
   import axi_burst_pkg::*, dma_ctrl_pkg::*;
(
   input  wire logic      aclk,
   input  wire logic      areset,
   // From the address engine
   input  wire logic      wr_start,
   input  wire axi_len_t  wr_start_len,
   // Local write stream
   input  wire axi_data_t wr_data,
   input  wire logic      wr_data_valid,
   output logic           wr_data_ready,
   // AXI write data
   output axi_w_t         m_axi_w,
   output logic           m_axi_wvalid,
   input  wire logic      m_axi_wready
);

   wr_data_state_e state;
   axi_len_t       beats_left;        // Beats still to go before the last one
   logic           enable;            // Stream gated onto W
   logic           beat;              // W handshake this cycle

   assign enable = (state != dw_idle);
   assign beat   = m_axi_wvalid && m_axi_wready;

   assign m_axi_wvalid  = enable && wr_data_valid;
   assign wr_data_ready = enable && m_axi_wready;
   assign m_axi_w.data  = wr_data;                   // Straight through
   assign m_axi_w.last  = (state == dw_last);

   ////////////////////////////////////////////////////////////
   // Beat counting
   ////////////////////////////////////////////////////////////
   always_ff @(posedge aclk) begin
      if (areset) begin
         state      <= dw_idle;
         beats_left <= '0;
      end else begin
         case (state)
            dw_idle: begin
               if (wr_start) begin
                  beats_left <= wr_start_len;
                  // Single beat burst goes straight to the WLAST beat
                  state <= (wr_start_len == '0) ? dw_last : dw_run;
               end
            end
            dw_run: begin
               if (beat) begin
                  beats_left <= beats_left - 1'b1;
                  if (beats_left == axi_len_t'(1)) begin
                     state <= dw_last;               // Next beat carries WLAST
                  end
               end
            end
            dw_last: begin
               if (beat) begin
                  state <= dw_idle;                  // Enable drops after WLAST
               end
            end
            default: state <= dw_idle;
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/dma_read_addr.sv */
// Read path address engine
// Takes a command, drives AR, waits for the data engine's end-of-burst verdict
`timescale 1ns/1ps
`default_nettype none

module dma_read_addr
   import axi_burst_pkg::*, dma_ctrl_pkg::*;
(
   input  wire logic     aclk,
   input  wire logic     areset,
   // Command side
   input  wire dma_cmd_t rd_cmd,
   input  wire logic     rd_cmd_valid,
   output logic          rd_cmd_ready,
   // AXI read address
   output axi_ax_t       m_axi_ar,
   output logic          m_axi_arvalid,
   input  wire logic     m_axi_arready,
   // Data engine handoff
   output logic          rd_start,
   output axi_len_t      rd_start_len,
   input  wire logic     rd_done,
   input  wire logic     rd_fail,
   // Status
   output logic          rd_error
);

   rd_addr_state_e state;
   logic           cmd_accept;

   assign cmd_accept = rd_cmd_valid && rd_cmd_ready;

   assign rd_cmd_ready  = (state == ar_idle);        // Low for the whole burst
   assign m_axi_arvalid = (state == ar_wait_ready);
   assign rd_error      = (state == ar_error);
   assign rd_start      = cmd_accept;
   assign rd_start_len  = rd_cmd.count;

   always_ff @(posedge aclk) begin
      if (areset) begin
         state <= ar_idle;
      end else begin
         case (state)
            ar_idle: begin
               if (cmd_accept) begin
                  state <= ar_wait_ready;
               end
            end
            ar_wait_ready: begin
               if (m_axi_arready) begin
                  state <= ar_wait_done;
               end
            end
            ar_wait_done: begin
               if (rd_fail) begin
                  state <= ar_error;                 // Stop until reset
               end else if (rd_done) begin
                  state <= ar_idle;
               end
            end
            default: state <= ar_error;
         endcase
      end
   end

   // AR payload, loaded on acceptance and held while arvalid is up
   always_ff @(posedge aclk) begin
      if (cmd_accept) begin
         m_axi_ar.addr <= rd_cmd.addr;
         m_axi_ar.len  <= rd_cmd.count;
      end
   end

endmodule

`default_nettype wire

/* src/dma_read_data.sv */
// Read path data engine
// Passes R beats to the local stream, checks RRESP and the RLAST position
`timescale 1ns/1ps
`default_nettype none

module dma_read_data
   import axi_burst_pkg::*, dma_ctrl_pkg::*;
(
   input  wire logic     aclk,
   input  wire logic     areset,
   // From the address engine
   input  wire logic     rd_start,
   input  wire axi_len_t rd_start_len,
   // AXI read data
   input  wire axi_r_t   m_axi_r,
   input  wire logic     m_axi_rvalid,
   output logic          m_axi_rready,
   // Local read stream
   output axi_data_t     rd_data,
   output logic          rd_data_valid,
   input  wire logic     rd_data_ready,
   // Verdict back to the address engine
   output logic          rd_done,
   output logic          rd_fail
);

   rd_data_state_e state;
   axi_len_t       expect_len;        // Index of the beat that must carry RLAST
   axi_len_t       beat_cnt;          // Beats taken so far
   logic           enable;
   logic           beat;
   logic           resp_bad;

   assign enable   = (state == dr_run) || (state == dr_drain);
   assign beat     = m_axi_rvalid && m_axi_rready;
   assign resp_bad = (m_axi_r.resp == resp_slverr) || (m_axi_r.resp == resp_decerr);

   assign rd_data       = m_axi_r.data;              // Straight through
   assign rd_data_valid = enable && m_axi_rvalid;
   assign m_axi_rready  = enable && rd_data_ready;

   ////////////////////////////////////////////////////////////
   // Beat checking
   ////////////////////////////////////////////////////////////
   always_ff @(posedge aclk) begin
      if (areset) begin
         state      <= dr_idle;
         expect_len <= '0;
         beat_cnt   <= '0;
         rd_done    <= 1'b0;
         rd_fail    <= 1'b0;
      end else begin
         rd_done <= 1'b0;                            // Single-cycle pulses
         rd_fail <= 1'b0;
         case (state)
            dr_idle: begin
               if (rd_start) begin
                  expect_len <= rd_start_len;
                  beat_cnt   <= '0;
                  state      <= dr_run;
               end
            end
            dr_run: begin
               if (beat) begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (resp_bad || (m_axi_r.last && (beat_cnt != expect_len))) begin
                     // Bad response or early RLAST
                     if (m_axi_r.last) begin
                        state   <= dr_error;
                        rd_fail <= 1'b1;
                     end else begin
                        state <= dr_drain;
                     end
                  end else if (m_axi_r.last) begin
                     state   <= dr_idle;             // Clean burst
                     rd_done <= 1'b1;
                  end else if (beat_cnt == expect_len) begin
                     state <= dr_drain;              // RLAST missing, late
                  end
               end
            end
            dr_drain: begin
               if (beat && m_axi_r.last) begin
                  state   <= dr_error;
                  rd_fail <= 1'b1;
               end
            end
            default: state <= dr_error;              // Hold until reset
         endcase
      end
   end

endmodule

`default_nettype wire

/* src/axi_dma_master.sv */
// AXI4 burst DMA master top, write and read channel engines
`timescale 1ns/1ps
`default_nettype none

module axi_dma_master
   import axi_burst_pkg::*, dma_ctrl_pkg::*;
(
   input  wire logic      aclk,
   input  wire logic      areset,
   // Write command and stream
   input  wire dma_cmd_t  wr_cmd,
   input  wire logic      wr_cmd_valid,
   output logic           wr_cmd_ready,
   input  wire axi_data_t wr_data,
   input  wire logic      wr_data_valid,
   output logic           wr_data_ready,
   // Read command and stream
   input  wire dma_cmd_t  rd_cmd,
   input  wire logic      rd_cmd_valid,
   output logic           rd_cmd_ready,
   output axi_data_t      rd_data,
   output logic           rd_data_valid,
   input  wire logic      rd_data_ready,
   // AXI write channels
   output axi_ax_t        m_axi_aw,
   output logic           m_axi_awvalid,
   input  wire logic      m_axi_awready,
   output axi_w_t         m_axi_w,
   output logic           m_axi_wvalid,
   input  wire logic      m_axi_wready,
   input  wire axi_resp_e m_axi_bresp,
   input  wire logic      m_axi_bvalid,
   output logic           m_axi_bready,
   // AXI read channels
   output axi_ax_t        m_axi_ar,
   output logic           m_axi_arvalid,
   input  wire logic      m_axi_arready,
   input  wire axi_r_t    m_axi_r,
   input  wire logic      m_axi_rvalid,
   output logic           m_axi_rready,
   // Status
   output logic           wr_error,
   output axi_resp_e      wr_error_resp,
   output logic           rd_error
);

   logic     wr_start;                // Address engine to data engine
   axi_len_t wr_start_len;
   logic     rd_start;
   axi_len_t rd_start_len;
   logic     rd_done;                 // Data engine verdict back to AR side
   logic     rd_fail;

   ////////////////////////////////////////////////////////////
   // Write path
   ////////////////////////////////////////////////////////////
   dma_write_addr u_write_addr (
      .aclk, .areset,
      .wr_cmd, .wr_cmd_valid, .wr_cmd_ready,
      .m_axi_aw, .m_axi_awvalid, .m_axi_awready,
      .m_axi_bresp, .m_axi_bvalid, .m_axi_bready,
      .wr_start, .wr_start_len,
      .wr_error, .wr_error_resp
   );

   dma_write_data u_write_data (
      .aclk, .areset,
      .wr_start, .wr_start_len,
      .wr_data, .wr_data_valid, .wr_data_ready,
      .m_axi_w, .m_axi_wvalid, .m_axi_wready
   );

   ////////////////////////////////////////////////////////////
   // Read path
   ////////////////////////////////////////////////////////////
   dma_read_addr u_read_addr (
      .aclk, .areset,
      .rd_cmd, .rd_cmd_valid, .rd_cmd_ready,
      .m_axi_ar, .m_axi_arvalid, .m_axi_arready,
      .rd_start, .rd_start_len,
      .rd_done, .rd_fail,
      .rd_error
   );

   dma_read_data u_read_data (
      .aclk, .areset,
      .rd_start, .rd_start_len,
      .m_axi_r, .m_axi_rvalid, .m_axi_rready,
      .rd_data, .rd_data_valid, .rd_data_ready,
      .rd_done, .rd_fail
   );

endmodule

`default_nettype wire

/* test/tb_axi_mem_responder.sv */
// AXI4 slave memory model for the DMA testbench
// Ready stalls and the B and R responses are set by the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_responder
   import axi_burst_pkg::*;
(
   input  wire logic      aclk,
   input  wire logic      areset,
   input  wire axi_ax_t   aw,
   input  wire logic      awvalid,
   output logic           awready,
   input  wire axi_w_t    w,
   input  wire logic      wvalid,
   output logic           wready,
   output axi_resp_e      bresp,
   output logic           bvalid,
   input  wire logic      bready,
   input  wire axi_ax_t   ar,
   input  wire logic      arvalid,
   output logic           arready,
   output axi_r_t         r,
   output logic           rvalid,
   input  wire logic      rready,
   // Stall and error controls from the testbench
   input  wire logic      aw_go,
   input  wire logic      w_go,
   input  wire logic      ar_go,
   input  wire logic      r_go,
   input  wire axi_resp_e b_resp_sel,
   input  wire axi_len_t  r_err_beat,     // Beat answered with DECERR
   input  wire logic      r_early,        // RLAST one beat early
   output logic           wlast_err       // Sticky flag for WLAST on the wrong beat
);

   axi_data_t  mem [0:255];               // Word addressed memory that wraps at 2 KiB
   logic [7:0] w_idx, r_idx, w_pos, r_pos;
   axi_len_t   w_len, w_cnt, r_len, r_cnt;
   logic       w_open, r_open;            // Burst accepted with beats pending

   assign w_pos   = w_idx + w_cnt;
   assign r_pos   = r_idx + r_cnt;
   assign awready = aw_go && !w_open && !bvalid;
   assign wready  = w_go && w_open;
   assign arready = ar_go && !r_open;
   assign bresp   = b_resp_sel;
   // R payload only moves on a handshake, so it holds while rvalid is up
   assign r.data  = mem[r_pos];
   assign r.resp  = (r_cnt == r_err_beat) ? resp_decerr : resp_okay;
   assign r.last  = r_early ? (r_cnt == r_len - 8'd1) : (r_cnt == r_len);

   always_ff @(posedge aclk) begin
      if (areset) begin
         w_open    <= 1'b0;
         bvalid    <= 1'b0;
         r_open    <= 1'b0;
         rvalid    <= 1'b0;
         w_cnt     <= '0;
         r_cnt     <= '0;
         wlast_err <= 1'b0;
      end else begin
         if (awvalid && awready) begin
            w_idx  <= aw.addr[10:3];
            w_len  <= aw.len;
            w_cnt  <= '0;
            w_open <= 1'b1;
         end
         if (wvalid && wready) begin
            mem[w_pos] <= w.data;
            w_cnt      <= w_cnt + 8'd1;
            if (w.last != (w_cnt == w_len)) wlast_err <= 1'b1;
            if (w_cnt == w_len) begin
               w_open <= 1'b0;
               bvalid <= 1'b1;            // Response after the final beat
            end
         end
         if (bvalid && bready) bvalid <= 1'b0;
         if (arvalid && arready) begin
            r_idx  <= ar.addr[10:3];
            r_len  <= ar.len;
            r_cnt  <= '0;
            r_open <= 1'b1;
         end
         if (rvalid && rready) begin
            rvalid <= 1'b0;
            r_cnt  <= r_cnt + 8'd1;
            if (r.last) r_open <= 1'b0;
         end else if (r_open && !rvalid && r_go) begin
            rvalid <= 1'b1;               // Random gap before each beat
         end
      end
   end

endmodule

`default_nettype wire

/* test/tb_axi_dma_master.sv */
// Testbench for the AXI DMA master
// Clock, reset, xorshift stimulus, memory model and compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_axi_dma_master
   import axi_burst_pkg::*, dma_ctrl_pkg::*;
();

   logic      aclk, areset;
   dma_cmd_t  wr_cmd, rd_cmd;
   logic      wr_cmd_valid, wr_cmd_ready, rd_cmd_valid, rd_cmd_ready;
   axi_data_t wr_data, rd_data;
   logic      wr_data_valid, wr_data_ready, rd_data_valid, rd_data_ready;
   axi_ax_t   m_axi_aw, m_axi_ar;
   logic      m_axi_awvalid, m_axi_awready, m_axi_arvalid, m_axi_arready;
   axi_w_t    m_axi_w;
   logic      m_axi_wvalid, m_axi_wready;
   axi_resp_e m_axi_bresp, wr_error_resp, b_resp_sel;
   logic      m_axi_bvalid, m_axi_bready;
   axi_r_t    m_axi_r;
   logic      m_axi_rvalid, m_axi_rready, wr_error, rd_error;
   logic      go_aw, go_w, go_ar, go_r, r_early, wlast_err;
   axi_len_t  r_err_beat;

   logic [31:0] rng_state = 32'd87;
   int unsigned stall_mod = 8;        // One cycle in stall_mod is stalled
   int unsigned cycles = 0, limit = 0;
   int unsigned err_count = 0, test_count = 0, test_fails = 0, mark = 0;
   int unsigned bst_idx [0:5];        // Start word of each burst
   axi_len_t    bst_cnt [0:5];
   axi_data_t   model_mem [0:255];

   axi_dma_master i_dut (.*);

   tb_axi_mem_responder i_mem (
      .aclk, .areset,
      .aw(m_axi_aw), .awvalid(m_axi_awvalid), .awready(m_axi_awready),
      .w(m_axi_w), .wvalid(m_axi_wvalid), .wready(m_axi_wready),
      .bresp(m_axi_bresp), .bvalid(m_axi_bvalid), .bready(m_axi_bready),
      .ar(m_axi_ar), .arvalid(m_axi_arvalid), .arready(m_axi_arready),
      .r(m_axi_r), .rvalid(m_axi_rvalid), .rready(m_axi_rready),
      .aw_go(go_aw), .w_go(go_w), .ar_go(go_ar), .r_go(go_r),
      .b_resp_sel, .r_err_beat, .r_early, .wlast_err
   );

   initial begin
      aclk = 1'b0;
      forever #4 aclk = ~aclk;        // 8 ns period
   end

   // Watchdog against a stuck handshake
   always @(posedge aclk) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles >= limit) begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////
   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [7:0] word_pos(int unsigned idx, int unsigned n);
      return 8'(idx + n);             // Memory wraps like the responder
   endfunction

   // Advance to 1 ns past the edge and redraw all ready stalls
   task automatic next_cycle();
      @(posedge aclk);
      #1;
      go_aw         = (next_rand() % stall_mod) != 0;
      go_w          = (next_rand() % stall_mod) != 0;
      go_ar         = (next_rand() % stall_mod) != 0;
      go_r          = (next_rand() % stall_mod) != 0;
      rd_data_ready = (next_rand() % stall_mod) != 0;
   endtask

   task automatic apply_reset();
      areset = 1'b1;
      repeat (5) next_cycle();
      areset = 1'b0;
   endtask

   task automatic check_data(string name, axi_data_t got, axi_data_t exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_resp(string name, axi_resp_e got, axi_resp_e exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("error %s got %h expected %h", name, got, exp);
         err_count++;
      end
   endtask

   task automatic end_test(string name);
      test_count++;
      if (err_count == mark) begin
         $display("test %0d %s: pass", test_count, name);
      end else begin
         $display("test %0d %s: fail", test_count, name);
         test_fails++;
      end
      mark = err_count;
   endtask

   // Command stays up until the cmd_ready handshake
   task automatic send_cmd(logic is_write, int unsigned idx, axi_len_t cnt);
      logic fire;
      fire = 1'b0;
      if (is_write) begin
         wr_cmd       = '{addr: axi_addr_t'(idx * beat_bytes), count: cnt};
         wr_cmd_valid = 1'b1;
      end else begin
         rd_cmd       = '{addr: axi_addr_t'(idx * beat_bytes), count: cnt};
         rd_cmd_valid = 1'b1;
      end
      while (!fire) begin
         @(negedge aclk);
         fire = is_write ? wr_cmd_ready : rd_cmd_ready;
         next_cycle();
      end
      wr_cmd_valid = 1'b0;
      rd_cmd_valid = 1'b0;
   endtask

   // Stopped path keeps its command ready low
   task automatic hold_check(string name);
      repeat (5) begin
         @(negedge aclk);
         check_flag(name, (name == "wr_cmd_ready") ? wr_cmd_ready : rd_cmd_ready, 1'b0);
         next_cycle();
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Burst tasks
   ////////////////////////////////////////////////////////////
   task automatic do_write(int unsigned idx, axi_len_t cnt, axi_resp_e resp);
      logic        fire;
      logic        done;
      axi_data_t   word;
      b_resp_sel = resp;
      send_cmd(1'b1, idx, cnt);
      for (int unsigned n = 0; n <= int'(cnt); n++) begin
         word = {next_rand(), next_rand()};
         if (next_rand() % 3 == 0) next_cycle();       // Idle gap on the stream
         wr_data       = word;
         wr_data_valid = 1'b1;
         fire          = 1'b0;
         while (!fire) begin
            @(negedge aclk);
            fire = wr_data_ready;
            check_flag("wr_cmd_ready", wr_cmd_ready, 1'b0);
            next_cycle();
         end
         wr_data_valid = 1'b0;
         model_mem[word_pos(idx, n)] = word;
      end
      done = 1'b0;
      while (!done) begin                              // Wait for B to settle
         @(negedge aclk);
         done = wr_cmd_ready || wr_error;
         next_cycle();
      end
      check_flag("wr_error", wr_error, (resp == resp_slverr) || (resp == resp_decerr));
      if (wr_error) check_resp("wr_error_resp", wr_error_resp, resp);
      check_flag("wlast_err", wlast_err, 1'b0);
      for (int unsigned n = 0; n <= int'(cnt); n++) begin
         check_data("mem", i_mem.mem[word_pos(idx, n)], model_mem[word_pos(idx, n)]);
      end
   endtask

   task automatic do_read(int unsigned idx, axi_len_t cnt, logic fail);
      int unsigned n;
      logic        done;
      send_cmd(1'b0, idx, cnt);
      n    = 0;
      done = 1'b0;
      while (!done) begin
         @(negedge aclk);
         if (rd_data_valid && rd_data_ready) begin
            if (!fail) check_data("rd_data", rd_data, model_mem[word_pos(idx, n)]);
            n++;
         end
         done = rd_cmd_ready || rd_error;
         next_cycle();
      end
      check_flag("rd_error", rd_error, fail);
      if (!fail) check_data("rd beats", axi_data_t'(n), axi_data_t'(cnt) + 64'd1);
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      areset        = 1'b1;
      wr_cmd        = '0;
      wr_cmd_valid  = 1'b0;
      wr_data       = '0;
      wr_data_valid = 1'b0;
      rd_cmd        = '0;
      rd_cmd_valid  = 1'b0;
      rd_data_ready = 1'b0;
      go_aw         = 1'b0;
      go_w          = 1'b0;
      go_ar         = 1'b0;
      go_r          = 1'b0;
      b_resp_sel    = resp_okay;
      r_err_beat    = 8'hff;
      r_early       = 1'b0;
      for (int i = 0; i < 6; i++) begin
         bst_idx[i] = next_rand() % 240;
         bst_cnt[i] = axi_len_t'(next_rand() % 16);
         limit += 2 * (40 * (int'(bst_cnt[i]) + 1) + 100);   // Write and read
      end
      limit += 3 * (40 * 5 + 100);                            // Error bursts
      apply_reset();

      for (int i = 0; i < 5; i++) do_write(bst_idx[i], bst_cnt[i], resp_okay);
      end_test("random write bursts");
      for (int i = 0; i < 5; i++) do_read(bst_idx[i], bst_cnt[i], 1'b0);
      end_test("random read bursts");
      stall_mod = 2;                                          // Heavy stalls
      do_write(bst_idx[5], bst_cnt[5], resp_okay);
      do_read(bst_idx[5], bst_cnt[5], 1'b0);
      stall_mod = 8;
      end_test("back-pressure");

      do_write(bst_idx[0], 8'd4, resp_slverr);
      hold_check("wr_cmd_ready");
      apply_reset();
      end_test("write response error");

      r_err_beat = 8'd2;                                      // DECERR mid burst
      do_read(bst_idx[1], 8'd4, 1'b1);
      hold_check("rd_cmd_ready");
      apply_reset();
      r_err_beat = 8'hff;
      r_early    = 1'b1;                                      // RLAST one beat early
      do_read(bst_idx[2], 8'd3, 1'b1);
      hold_check("rd_cmd_ready");
      r_early = 1'b0;
      end_test("read errors");

      $display("%0d tests, %0d failed, %0d errors", test_count, test_fails, err_count);
      if (err_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
src/axi_burst_pkg.sv
src/dma_ctrl_pkg.sv
src/dma_write_addr.sv
src/dma_write_data.sv
src/dma_read_addr.sv
src/dma_read_data.sv
src/axi_dma_master.sv
test/tb_axi_mem_responder.sv
test/tb_axi_dma_master.sv

/* Makefile */
# Verilator build and run for the AXI DMA master testbench

TOP := tb_axi_dma_master

.PHONY: compile run clean

compile:
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
